/* project.f */
src/lc3b_pkg.sv
src/lc3b_control_rom.sv
src/lc3b_regfile.sv
src/lc3b_execute.sv
src/lc3b_dependency_logic.sv
src/lc3b_mem_stage.sv
src/lc3b_datapath.sv
src/lc3b_cpu.sv
sim/lc3b_cpu_checker.sv
sim/tb_lc3b_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the LC-3b pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f project.f --top-module tb_lc3b_cpu \
	-Mdir obj_dir -o tb_lc3b_cpu > build.log 2>&1 \
	&& ./obj_dir/tb_lc3b_cpu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/lc3b_cpu_checker.sv */
`timescale 1ns/1ps
module lc3b_cpu_checker (
	input logic clk,
	input logic rst_n,
	input logic imem_read,
	input lc3b_pkg::lc3b_word imem_address,
	input logic imem_resp,
	input logic dmem_read,
	input logic dmem_write,
	input lc3b_pkg::lc3b_word dmem_address,
	input lc3b_pkg::lc3b_word dmem_wdata,
	input logic [1:0] dmem_byte_enable,
	input logic dmem_resp
);

	logic in_reset_q;	// Reset seen at the previous edge

	always_ff @(posedge clk) in_reset_q <= !rst_n;

	// Outputs settle low one cycle into reset
	assert property (@(posedge clk) (!rst_n && in_reset_q) |-> !(imem_read | dmem_read | dmem_write))
		else $error("memory request raised during reset");

	assert property (@(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write))
		else $error("data read and write high together");

	assert property (@(posedge clk) disable iff (!rst_n)
		(imem_read && !imem_resp) |=> (imem_read && $stable(imem_address)))
		else $error("instruction request dropped or changed before response");

	assert property (@(posedge clk) disable iff (!rst_n)
		((dmem_read || dmem_write) && !dmem_resp) |=> ($stable(dmem_read) && $stable(dmem_write)
		&& $stable(dmem_address) && $stable(dmem_wdata) && $stable(dmem_byte_enable)))
		else $error("data request changed before response");

	assert property (@(posedge clk) disable iff (!rst_n)
		dmem_write |-> (dmem_byte_enable == 2'b11 || $onehot(dmem_byte_enable)))
		else $error("byte write without exactly one lane enabled");

endmodule

bind lc3b_cpu lc3b_cpu_checker checker0 (
	.clk(clk), .rst_n(rst_n), .imem_read(imem_read), .imem_address(imem_address),
	.imem_resp(imem_resp), .dmem_read(dmem_read), .dmem_write(dmem_write),
	.dmem_address(dmem_address), .dmem_wdata(dmem_wdata),
	.dmem_byte_enable(dmem_byte_enable), .dmem_resp(dmem_resp)
);

/* sim/tb_lc3b_cpu.sv */
`timescale 1ns/1ps
module tb_lc3b_cpu;

	localparam int cycle_limit = 4000;	// Six tests with worst-case waits fit well inside
	localparam logic [3:0] add_op = 4'b0001;
	localparam logic [3:0] and_op = 4'b0101;
	localparam logic [3:0] ldb_op = 4'b0010;
	localparam logic [3:0] stb_op = 4'b0011;
	localparam logic [3:0] ldr_op = 4'b0110;
	localparam logic [3:0] str_op = 4'b0111;

	logic clk, rst_n;
	logic [15:0] imem_rdata, dmem_rdata, imem_address, dmem_address, dmem_wdata;
	logic imem_resp, dmem_resp, imem_read, dmem_read, dmem_write;
	logic [1:0] dmem_byte_enable;

	logic [15:0] imem [256];	// Word-indexed program store
	logic [7:0] dmem [65536];	// Byte-addressed data store
	logic [31:0] lfsr_state;
	logic waits_on, marker_seen, i_busy, d_busy, pass_done, fail_done;
	int i_wait, d_wait, cycles, wp;

	lc3b_cpu dut0 (
		.clk, .rst_n, .imem_rdata, .imem_resp, .dmem_rdata, .dmem_resp,
		.imem_read, .imem_address, .dmem_read, .dmem_write, .dmem_address,
		.dmem_wdata, .dmem_byte_enable
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32, 22, 2, 1
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic pick_wait(output int w);
		logic [31:0] v;
		w = 0;
		if (waits_on) begin
			draw_bits(2, v);
			w = int'(v[1:0]);	// 0 to 3 wait cycles
		end
	endtask

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	function automatic logic [15:0] read_word(input logic [15:0] a);
		return {dmem[{a[15:1], 1'b1}], dmem[{a[15:1], 1'b0}]};
	endfunction

	// Instruction encoders
	function automatic logic [15:0] op_rr(input logic [3:0] opc, input int dr, input int s1,
		input int s2);
		return {opc, dr[2:0], s1[2:0], 3'b000, s2[2:0]};
	endfunction

	function automatic logic [15:0] op_ri(input logic [3:0] opc, input int dr, input int s1,
		input int imm);
		return {opc, dr[2:0], s1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic logic [15:0] op_not(input int dr, input int s1);
		return {4'b1001, dr[2:0], s1[2:0], 6'b111111};
	endfunction

	function automatic logic [15:0] op_shf(input int dr, input int s1, input logic [1:0] kind,
		input int amt);
		return {4'b1101, dr[2:0], s1[2:0], kind, amt[3:0]};	// kind is {A, D}
	endfunction

	function automatic logic [15:0] op_mem(input logic [3:0] opc, input int r, input int base,
		input int off);
		return {opc, r[2:0], base[2:0], off[5:0]};
	endfunction

	function automatic logic [15:0] op_lea(input int dr, input int off);
		return {4'b1110, dr[2:0], off[8:0]};
	endfunction

	function automatic logic [15:0] op_br(input logic [2:0] nzp, input int off);
		return {4'b0000, nzp, off[8:0]};
	endfunction

	function automatic logic [15:0] op_jmp(input int base);
		return {4'b1100, 3'b000, base[2:0], 6'b000000};
	endfunction

	function automatic logic [15:0] op_jsr(input int off);
		return {4'b0100, 1'b1, off[10:0]};
	endfunction

	task automatic check_equal(input logic [15:0] got, input logic [15:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAIL %0d ns: %s (got %h, expected %h)", $time, msg, got, exp);
			$display(">>> FAIL");
			fail_done = 1'b1;
			$fatal(1, "mismatch");
		end
	endtask

	task automatic new_program();
		for (int k = 0; k < 256; k++)
			imem[k] = 16'h0000;	// BR with empty mask never branches
		wp = 0;
	endtask

	task automatic put(input logic [15:0] w);
		imem[wp] = w;
		wp++;
	endtask

	// Marker store to 16'hfffe, then a branch to itself
	task automatic run_program();
		put(op_mem(str_op, 0, 0, -1));
		put(op_br(3'b111, -1));
		@(posedge clk);
		#1 rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		marker_seen = 1'b0;
		for (int a = 0; a < 65536; a++)
			dmem[a] = fill_byte(16'(a));
		do @(posedge clk); while (!marker_seen);
	endtask

	// Zero-wait memories answer in the cycle of the request
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (imem_read) begin
				if (!i_busy) begin
					pick_wait(i_wait);
					i_busy = 1'b1;
				end
				if (i_wait == 0) begin
					imem_resp = 1'b1;
					imem_rdata = imem[imem_address[8:1]];
					i_busy = 1'b0;
				end else begin
					imem_resp = 1'b0;
					i_wait = i_wait - 1;
				end
			end else begin
				imem_resp = 1'b0;
				i_busy = 1'b0;
			end
			if (dmem_read || dmem_write) begin
				if (!d_busy) begin
					pick_wait(d_wait);
					d_busy = 1'b1;
				end
				if (d_wait == 0) begin
					dmem_resp = 1'b1;
					d_busy = 1'b0;
					if (dmem_write) begin
						if (dmem_byte_enable[0])
							dmem[{dmem_address[15:1], 1'b0}] = dmem_wdata[7:0];
						if (dmem_byte_enable[1])
							dmem[{dmem_address[15:1], 1'b1}] = dmem_wdata[15:8];
						if (dmem_address == 16'hfffe)
							marker_seen = 1'b1;
					end else begin
						dmem_rdata = read_word(dmem_address);
					end
				end else begin
					dmem_resp = 1'b0;
					d_wait = d_wait - 1;
				end
			end else begin
				dmem_resp = 1'b0;
				d_busy = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the program never reached its marker store");
			$display(">>> FAIL");
			fail_done = 1'b1;
			$fatal(1, "timeout");
		end
	end

	// Operands a = R1, b = R2 built from LEA plus ADD immediate
	task automatic test_alu(input int off_a, input int imm_a, input int off_b, input int imm_b,
		input int s1, input int s2, input int s3, input int imm_c);
		logic [15:0] a, b;
		a = 16'(2 + 2 * off_a + imm_a);	// LEA at word 0 sees PC+2 of 2
		b = 16'(6 + 2 * off_b + imm_b);
		new_program();
		put(op_lea(1, off_a));
		put(op_ri(add_op, 1, 1, imm_a));
		put(op_lea(2, off_b));
		put(op_ri(add_op, 2, 2, imm_b));
		put(op_rr(add_op, 3, 1, 2));
		put(op_mem(str_op, 3, 0, 0));
		put(op_rr(and_op, 3, 1, 2));
		put(op_mem(str_op, 3, 0, 1));
		put(op_not(3, 1));
		put(op_mem(str_op, 3, 0, 2));
		put(op_shf(3, 1, 2'b00, s1));
		put(op_mem(str_op, 3, 0, 3));
		put(op_shf(3, 1, 2'b01, s2));
		put(op_mem(str_op, 3, 0, 4));
		put(op_shf(3, 1, 2'b11, s3));
		put(op_mem(str_op, 3, 0, 5));
		put(op_ri(add_op, 3, 1, imm_c));
		put(op_mem(str_op, 3, 0, 6));
		put(op_ri(and_op, 3, 1, imm_c));
		put(op_mem(str_op, 3, 0, 7));
		run_program();
		check_equal(read_word(16'd0), a + b, "ADD register");
		check_equal(read_word(16'd2), a & b, "AND register");
		check_equal(read_word(16'd4), ~a, "NOT");
		check_equal(read_word(16'd6), a << s1[3:0], "LSHF");
		check_equal(read_word(16'd8), a >> s2[3:0], "RSHFL");
		check_equal(read_word(16'd10),
			(a >> s3[3:0]) | (~(16'hffff >> s3[3:0]) & {16{a[15]}}), "RSHFA");
		check_equal(read_word(16'd12), a + 16'(imm_c), "ADD immediate");
		check_equal(read_word(16'd14), a & 16'(imm_c), "AND immediate");
	endtask

	task automatic test_memory();
		new_program();
		put(op_ri(add_op, 1, 0, 13));
		put(op_shf(1, 1, 2'b00, 8));
		put(op_ri(add_op, 1, 1, -11));	// R1 = 16'h0cf5
		put(op_mem(str_op, 1, 0, 4));
		put(op_mem(ldr_op, 2, 0, 4));
		put(op_mem(str_op, 2, 0, 5));
		put(op_mem(stb_op, 1, 0, 21));	// Odd byte lane
		put(op_mem(stb_op, 1, 0, 22));	// Even byte lane
		put(op_mem(ldb_op, 3, 0, 21));
		put(op_mem(str_op, 3, 0, 8));
		put(op_mem(ldb_op, 4, 0, 9));
		put(op_mem(str_op, 4, 0, 9));
		run_program();
		check_equal(read_word(16'd8), 16'h0cf5, "STR word");
		check_equal(read_word(16'd10), 16'h0cf5, "LDR round trip");
		check_equal(read_word(16'd20), {8'hf5, fill_byte(16'd20)}, "STB high lane");
		check_equal(read_word(16'd22), {fill_byte(16'd23), 8'hf5}, "STB low lane");
		check_equal(read_word(16'd16), 16'h00f5, "LDB zero extension");
		check_equal(read_word(16'd18), 16'h000c, "LDB high byte");
	endtask

	task automatic test_dependency();
		logic [15:0] r1, r2, r3, r4, r5, r6;
		r1 = 16'd3;
		r2 = r1 + r1;
		r1 = r2 - 16'd1;
		r3 = r1 + r2;
		r4 = r3 & r1;
		r5 = ~r4;
		r6 = r5 + r3;
		new_program();
		put(op_ri(add_op, 1, 0, 3));
		put(op_rr(add_op, 2, 1, 1));
		put(op_ri(add_op, 1, 2, -1));
		put(op_rr(add_op, 3, 1, 2));
		put(op_rr(and_op, 4, 3, 1));
		put(op_not(5, 4));
		put(op_rr(add_op, 6, 5, 3));
		for (int k = 1; k <= 6; k++)
			put(op_mem(str_op, k, 0, k - 1));
		run_program();
		check_equal(read_word(16'd0), r1, "chain R1");
		check_equal(read_word(16'd2), r2, "chain R2");
		check_equal(read_word(16'd4), r3, "chain R3");
		check_equal(read_word(16'd6), r4, "chain R4");
		check_equal(read_word(16'd8), r5, "chain R5");
		check_equal(read_word(16'd10), r6, "chain R6");
	endtask

	task automatic test_branch();
		new_program();
		put(op_ri(add_op, 1, 0, -3));	// cc = n
		put(op_br(3'b100, 1));	// Taken
		put(op_ri(add_op, 2, 0, 5));
		put(op_br(3'b010, 1));	// Not taken
		put(op_ri(add_op, 3, 0, 7));
		put(op_ri(add_op, 4, 0, 0));	// cc = z
		put(op_br(3'b010, 1));	// Taken
		put(op_ri(add_op, 7, 0, 1));
		put(op_br(3'b001, 1));	// Not taken
		put(op_ri(add_op, 5, 0, 2));	// cc = p
		put(op_br(3'b001, 1));	// Taken
		put(op_ri(add_op, 6, 0, 1));
		put(op_mem(str_op, 2, 0, 0));
		put(op_mem(str_op, 3, 0, 1));
		put(op_mem(str_op, 5, 0, 2));
		put(op_mem(str_op, 6, 0, 3));
		put(op_mem(str_op, 7, 0, 4));
		run_program();
		check_equal(read_word(16'd0), 16'd0, "BRn skip");
		check_equal(read_word(16'd2), 16'd7, "BRz fall through");
		check_equal(read_word(16'd4), 16'd2, "BRp fall through");
		check_equal(read_word(16'd6), 16'd0, "BRp skip");
		check_equal(read_word(16'd8), 16'd0, "BRz skip");
	endtask

	task automatic test_jump();
		new_program();
		put(op_ri(add_op, 1, 0, 1));
		put(op_jsr(2));	// To word 4, R7 = 4
		put(op_ri(add_op, 2, 0, 9));
		put(op_ri(add_op, 3, 0, 3));
		put(op_ri(add_op, 4, 0, 5));
		put(op_lea(5, 2));	// R5 = 16, word 8
		put(op_jmp(5));
		put(op_ri(add_op, 6, 0, -1));
		put(op_mem(str_op, 7, 0, 0));
		put(op_mem(str_op, 2, 0, 1));
		put(op_mem(str_op, 3, 0, 2));
		put(op_mem(str_op, 4, 0, 3));
		put(op_mem(str_op, 6, 0, 4));
		put(op_mem(str_op, 1, 0, 5));
		run_program();
		check_equal(read_word(16'd0), 16'd4, "JSR link");
		check_equal(read_word(16'd2), 16'd0, "JSR skip first");
		check_equal(read_word(16'd4), 16'd0, "JSR skip second");
		check_equal(read_word(16'd6), 16'd5, "JSR target");
		check_equal(read_word(16'd8), 16'd0, "JMP skip");
		check_equal(read_word(16'd10), 16'd1, "before JSR");
	endtask

	initial begin
		logic [31:0] v;
		int oa, ia, ob, ib, s1, s2, s3, ic;
		rst_n = 1'b0;
		imem_rdata = '0;
		imem_resp = 1'b0;
		dmem_rdata = '0;
		dmem_resp = 1'b0;
		lfsr_state = 32'hbfec;
		waits_on = 1'b0;
		marker_seen = 1'b0;
		i_busy = 1'b0;
		d_busy = 1'b0;
		pass_done = 1'b0;
		fail_done = 1'b0;
		cycles = 0;
		draw_bits(9, v);
		oa = int'($signed(v[8:0]));
		draw_bits(5, v);
		ia = int'($signed(v[4:0]));
		draw_bits(9, v);
		ob = int'($signed(v[8:0]));
		draw_bits(5, v);
		ib = int'($signed(v[4:0]));
		draw_bits(4, v);
		s1 = int'(v[3:0]);
		draw_bits(4, v);
		s2 = int'(v[3:0]);
		draw_bits(4, v);
		s3 = int'(v[3:0]);
		draw_bits(5, v);
		ic = int'($signed(v[4:0]));
		test_alu(oa, ia, ob, ib, s1, s2, s3, ic);
		test_memory();
		test_dependency();
		test_branch();
		test_jump();
		waits_on = 1'b1;	// Same ALU program under random wait states
		test_alu(oa, ia, ob, ib, s1, s2, s3, ic);
		$display(">>> PASS");
		pass_done = 1'b1;
		$finish;
	end

	final begin
		if (!pass_done && !fail_done)
			$display(">>> FAIL");
	end

endmodule

/* src/lc3b_control_rom.sv */
`timescale 1ns/1ps
module lc3b_control_rom (
	input lc3b_pkg::lc3b_word ir,
	output lc3b_pkg::lc3b_ctrl ctrl_word
);

	lc3b_pkg::lc3b_opcode opcode;

	assign opcode = lc3b_pkg::lc3b_opcode'(ir[15:12]);

	always_comb begin
		ctrl_word = '0;	// Unused opcodes load nothing
		case (opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				ctrl_word[lc3b_pkg::ctrl_ld_reg] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_ld_cc] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_sr1_needed] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_sr2_needed] = ~ir[5];	// Register form only
				ctrl_word[lc3b_pkg::ctrl_use_imm5] = ir[5];
				if (opcode == lc3b_pkg::op_and)
					ctrl_word[lc3b_pkg::ctrl_alu_op +: 2] = lc3b_pkg::alu_and;
				else
					ctrl_word[lc3b_pkg::ctrl_alu_op +: 2] = lc3b_pkg::alu_add;
			end
			lc3b_pkg::op_not, lc3b_pkg::op_shf: begin
				ctrl_word[lc3b_pkg::ctrl_ld_reg] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_ld_cc] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_sr1_needed] = 1'b1;
				if (opcode == lc3b_pkg::op_not)
					ctrl_word[lc3b_pkg::ctrl_alu_op +: 2] = lc3b_pkg::alu_not;
				else
					ctrl_word[lc3b_pkg::ctrl_alu_op +: 2] = lc3b_pkg::alu_shift;
			end
			lc3b_pkg::op_ldr, lc3b_pkg::op_ldb: begin
				ctrl_word[lc3b_pkg::ctrl_ld_reg] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_ld_cc] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_sr1_needed] = 1'b1;	// Base register
				ctrl_word[lc3b_pkg::ctrl_mem_read] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_byte_op] = (opcode == lc3b_pkg::op_ldb);
				ctrl_word[lc3b_pkg::ctrl_wb_sel +: 2] = lc3b_pkg::wb_load;
			end
			lc3b_pkg::op_str, lc3b_pkg::op_stb: begin
				ctrl_word[lc3b_pkg::ctrl_sr1_needed] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_sr2_needed] = 1'b1;	// Store data on port b
				ctrl_word[lc3b_pkg::ctrl_mem_write] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_byte_op] = (opcode == lc3b_pkg::op_stb);
			end
			lc3b_pkg::op_lea: begin
				ctrl_word[lc3b_pkg::ctrl_ld_reg] = 1'b1;	// LC-3b LEA leaves cc alone
				ctrl_word[lc3b_pkg::ctrl_addr_sel] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_wb_sel +: 2] = lc3b_pkg::wb_addr;
			end
			lc3b_pkg::op_br: begin
				ctrl_word[lc3b_pkg::ctrl_br_op] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_addr_sel] = 1'b1;
			end
			lc3b_pkg::op_jmp: begin
				ctrl_word[lc3b_pkg::ctrl_jmp_op] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_sr1_needed] = 1'b1;
			end
			lc3b_pkg::op_jsr: begin
				ctrl_word[lc3b_pkg::ctrl_jsr_op] = 1'b1;
				ctrl_word[lc3b_pkg::ctrl_ld_reg] = 1'b1;	// R7 gets PC+2
				ctrl_word[lc3b_pkg::ctrl_addr_sel] = ir[11];	// JSR is PC-relative
				ctrl_word[lc3b_pkg::ctrl_sr1_needed] = ~ir[11];	// JSRR reads BaseR
				ctrl_word[lc3b_pkg::ctrl_wb_sel +: 2] = lc3b_pkg::wb_pc;
			end
			default: ctrl_word = '0;
		endcase
	end

endmodule

/* src/lc3b_cpu.sv */
`timescale 1ns/1ps
module lc3b_cpu #(
	parameter lc3b_pkg::lc3b_word reset_pc = 16'h0000	// Boot address
) (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word imem_rdata,
	input logic imem_resp,
	input lc3b_pkg::lc3b_word dmem_rdata,
	input logic dmem_resp,
	output logic imem_read,
	output lc3b_pkg::lc3b_word imem_address,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_pkg::lc3b_word dmem_address,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic [1:0] dmem_byte_enable
);

	lc3b_pkg::lc3b_word if_id_ir;	// Decode-stage instruction
	lc3b_pkg::lc3b_ctrl ctrl_word;

	lc3b_control_rom control_rom0 (
		.ir(if_id_ir),
		.ctrl_word
	);

	lc3b_datapath #(.reset_pc(reset_pc)) datapath0 (
		.clk, .rst_n,
		.imem_rdata, .imem_resp, .dmem_rdata, .dmem_resp,
		.imem_read, .imem_address,
		.dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_byte_enable,
		.if_id_ir, .ctrl_word
	);

endmodule

/* src/lc3b_datapath.sv */
`timescale 1ns/1ps
module lc3b_datapath #(
	parameter lc3b_pkg::lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word imem_rdata,
	input logic imem_resp,
	input lc3b_pkg::lc3b_word dmem_rdata,
	input logic dmem_resp,
	output logic imem_read,
	output lc3b_pkg::lc3b_word imem_address,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_pkg::lc3b_word dmem_address,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic [1:0] dmem_byte_enable,
	output lc3b_pkg::lc3b_word if_id_ir,
	input lc3b_pkg::lc3b_ctrl ctrl_word
);

	lc3b_pkg::lc3b_word pc, pc_plus2;
	logic fetch_en;	// Set one cycle after reset ends
	logic fetch_ok;
	logic branch_pending;

	lc3b_pkg::lc3b_word if_id_pc;
	logic if_id_valid;

	lc3b_pkg::lc3b_opcode id_opcode;
	lc3b_pkg::lc3b_reg id_src_b, id_dr;
	lc3b_pkg::lc3b_word id_sr1, id_sr2;
	logic dep_stall;

	lc3b_pkg::lc3b_word id_ex_ir, id_ex_pc, id_ex_sr1, id_ex_sr2;
	lc3b_pkg::lc3b_reg id_ex_dr;
	lc3b_pkg::lc3b_ctrl id_ex_ctrl;
	logic id_ex_valid;
	lc3b_pkg::lc3b_word ex_result, ex_address;

	lc3b_pkg::lc3b_word ex_mem_ir, ex_mem_pc, ex_mem_result, ex_mem_address, ex_mem_sdata;
	lc3b_pkg::lc3b_reg ex_mem_dr;
	lc3b_pkg::lc3b_ctrl ex_mem_ctrl;
	logic ex_mem_valid;
	lc3b_pkg::lc3b_word mem_load_data, mem_target;
	logic mem_stall, mem_redirect;

	lc3b_pkg::lc3b_word mem_wb_pc, mem_wb_result, mem_wb_address, mem_wb_data;
	lc3b_pkg::lc3b_reg mem_wb_dr;
	lc3b_pkg::lc3b_ctrl mem_wb_ctrl;
	logic mem_wb_valid;
	lc3b_pkg::lc3b_word wb_data;
	lc3b_pkg::lc3b_cc cc, wb_cc;
	logic wb_ld_reg, wb_ld_cc;

	function automatic logic is_flow(input lc3b_pkg::lc3b_ctrl c);
		return c[lc3b_pkg::ctrl_br_op] | c[lc3b_pkg::ctrl_jmp_op] | c[lc3b_pkg::ctrl_jsr_op];
	endfunction

	// No fetch from the moment a control op is decoded until it leaves MEM
	assign branch_pending = (if_id_valid & is_flow(ctrl_word))
		| (id_ex_valid & is_flow(id_ex_ctrl)) | (ex_mem_valid & is_flow(ex_mem_ctrl));

	assign pc_plus2 = pc + 16'd2;
	assign imem_read = fetch_en & ~branch_pending;
	assign imem_address = pc;
	assign fetch_ok = imem_read & imem_resp & ~mem_stall & ~dep_stall;	// Refetch if ID is held

	assign id_opcode = lc3b_pkg::lc3b_opcode'(if_id_ir[15:12]);
	assign id_src_b = (id_opcode == lc3b_pkg::op_str || id_opcode == lc3b_pkg::op_stb)
		? if_id_ir[11:9] : if_id_ir[2:0];	// Stores read SR from IR[11:9]
	assign id_dr = (id_opcode == lc3b_pkg::op_jsr) ? 3'b111 : if_id_ir[11:9];

	assign wb_ld_reg = mem_wb_valid & mem_wb_ctrl[lc3b_pkg::ctrl_ld_reg];
	assign wb_ld_cc = mem_wb_valid & mem_wb_ctrl[lc3b_pkg::ctrl_ld_cc];

	lc3b_regfile regfile0 (
		.clk, .rst_n, .load(wb_ld_reg), .dest(mem_wb_dr), .in(wb_data),
		.src_a(if_id_ir[8:6]), .src_b(id_src_b), .reg_a(id_sr1), .reg_b(id_sr2)
	);

	lc3b_dependency_logic dependency_logic0 (
		.sr1(if_id_ir[8:6]), .sr2(id_src_b),
		.sr1_needed(if_id_valid & ctrl_word[lc3b_pkg::ctrl_sr1_needed]),
		.sr2_needed(if_id_valid & ctrl_word[lc3b_pkg::ctrl_sr2_needed]),
		.br_op(if_id_valid & ctrl_word[lc3b_pkg::ctrl_br_op]),
		.ex_dr(id_ex_dr), .mem_dr(ex_mem_dr), .wb_dr(mem_wb_dr),
		.ex_ld_reg(id_ex_valid & id_ex_ctrl[lc3b_pkg::ctrl_ld_reg]),
		.mem_ld_reg(ex_mem_valid & ex_mem_ctrl[lc3b_pkg::ctrl_ld_reg]),
		.wb_ld_reg(wb_ld_reg),
		.ex_ld_cc(id_ex_valid & id_ex_ctrl[lc3b_pkg::ctrl_ld_cc]),
		.mem_ld_cc(ex_mem_valid & ex_mem_ctrl[lc3b_pkg::ctrl_ld_cc]),
		.wb_ld_cc(wb_ld_cc), .dep_stall
	);

	lc3b_execute execute0 (
		.ir(id_ex_ir), .pc(id_ex_pc), .sr1(id_ex_sr1), .sr2(id_ex_sr2), .ctrl(id_ex_ctrl),
		.result(ex_result), .address(ex_address)
	);

	assign dmem_address = ex_mem_address;

	lc3b_mem_stage mem_stage0 (
		.ctrl(ex_mem_ctrl), .valid(ex_mem_valid), .address(ex_mem_address),
		.store_data(ex_mem_sdata), .ir_nzp(ex_mem_ir[11:9]), .cc, .dmem_rdata, .dmem_resp,
		.dmem_read, .dmem_write, .dmem_wdata, .dmem_byte_enable,
		.load_data(mem_load_data), .mem_stall, .redirect(mem_redirect), .target(mem_target)
	);

	always_comb begin
		case (mem_wb_ctrl[lc3b_pkg::ctrl_wb_sel +: 2])
			lc3b_pkg::wb_alu: wb_data = mem_wb_result;
			lc3b_pkg::wb_addr: wb_data = mem_wb_address;
			lc3b_pkg::wb_load: wb_data = mem_wb_data;
			default: wb_data = mem_wb_pc;	// JSR link
		endcase
	end

	assign wb_cc = {wb_data[15], wb_data == 16'h0000, ~wb_data[15] & (wb_data != 16'h0000)};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_en <= 1'b0;
			pc <= reset_pc;
			if_id_valid <= 1'b0;
			id_ex_valid <= 1'b0;
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
			cc <= 3'b010;	// Z
		end else begin
			fetch_en <= 1'b1;
			if (mem_redirect)
				pc <= mem_target;	// Taken when the control op leaves MEM
			else if (fetch_ok)
				pc <= pc_plus2;
			if (!(mem_stall | dep_stall))
				if_id_valid <= fetch_ok;	// Bubble into decode on a missed fetch
			if (!mem_stall) begin
				id_ex_valid <= if_id_valid & ~dep_stall;	// Bubble into EX on dep stall
				ex_mem_valid <= id_ex_valid;
				mem_wb_valid <= ex_mem_valid;
			end
			if (wb_ld_cc)
				cc <= wb_cc;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_ok) begin
			if_id_ir <= imem_rdata;
			if_id_pc <= pc_plus2;
		end
		if (!mem_stall) begin
			id_ex_ir <= if_id_ir;
			id_ex_pc <= if_id_pc;
			id_ex_sr1 <= id_sr1;
			id_ex_sr2 <= id_sr2;
			id_ex_dr <= id_dr;
			id_ex_ctrl <= ctrl_word;
			ex_mem_ir <= id_ex_ir;
			ex_mem_pc <= id_ex_pc;
			ex_mem_result <= ex_result;
			ex_mem_address <= ex_address;
			ex_mem_sdata <= id_ex_sr2;	// Store data rides with the address
			ex_mem_dr <= id_ex_dr;
			ex_mem_ctrl <= id_ex_ctrl;
			mem_wb_pc <= ex_mem_pc;
			mem_wb_result <= ex_mem_result;
			mem_wb_address <= ex_mem_address;
			mem_wb_data <= mem_load_data;
			mem_wb_dr <= ex_mem_dr;
			mem_wb_ctrl <= ex_mem_ctrl;
		end
	end

endmodule

/* src/lc3b_dependency_logic.sv */
`timescale 1ns/1ps
module lc3b_dependency_logic (
	input lc3b_pkg::lc3b_reg sr1,
	input lc3b_pkg::lc3b_reg sr2,
	input logic sr1_needed,
	input logic sr2_needed,
	input logic br_op,
	input lc3b_pkg::lc3b_reg ex_dr,
	input lc3b_pkg::lc3b_reg mem_dr,
	input lc3b_pkg::lc3b_reg wb_dr,
	input logic ex_ld_reg,
	input logic mem_ld_reg,
	input logic wb_ld_reg,
	input logic ex_ld_cc,
	input logic mem_ld_cc,
	input logic wb_ld_cc,
	output logic dep_stall
);

	logic sr1_hit, sr2_hit, cc_hit;

	// Writer flags arrive already qualified by each stage's valid bit
	// A register writer in WB reaches decode through the register file write-through
	assign sr1_hit = sr1_needed & ((ex_ld_reg & (ex_dr == sr1))
		| (mem_ld_reg & (mem_dr == sr1)));

	assign sr2_hit = sr2_needed & ((ex_ld_reg & (ex_dr == sr2))
		| (mem_ld_reg & (mem_dr == sr2)));

	assign cc_hit = br_op & (ex_ld_cc | mem_ld_cc | wb_ld_cc);	// Any pending cc writer

	assign dep_stall = sr1_hit | sr2_hit | cc_hit;

endmodule

/* src/lc3b_execute.sv */
`timescale 1ns/1ps
module lc3b_execute (
	input lc3b_pkg::lc3b_word ir,
	input lc3b_pkg::lc3b_word pc,	// Already PC+2
	input lc3b_pkg::lc3b_word sr1,
	input lc3b_pkg::lc3b_word sr2,
	input lc3b_pkg::lc3b_ctrl ctrl,
	output lc3b_pkg::lc3b_word result,
	output lc3b_pkg::lc3b_word address
);

	lc3b_pkg::lc3b_word sext5, sext6, sext9, sext11;
	lc3b_pkg::lc3b_word alu_b, alu_out, shf_out;
	lc3b_pkg::lc3b_word addr_base, addr_off;
	logic [1:0] alu_op;

	assign sext5 = {{11{ir[4]}}, ir[4:0]};
	assign sext6 = {{10{ir[5]}}, ir[5:0]};
	assign sext9 = {{7{ir[8]}}, ir[8:0]};
	assign sext11 = {{5{ir[10]}}, ir[10:0]};

	assign alu_op = ctrl[lc3b_pkg::ctrl_alu_op +: 2];
	assign alu_b = ctrl[lc3b_pkg::ctrl_use_imm5] ? sext5 : sr2;

	always_comb begin
		case (alu_op)
			lc3b_pkg::alu_add: alu_out = sr1 + alu_b;
			lc3b_pkg::alu_and: alu_out = sr1 & alu_b;
			default: alu_out = ~sr1;	// NOT
		endcase
	end

	always_comb begin
		if (!ir[4])
			shf_out = sr1 << ir[3:0];	// LSHF
		else if (!ir[5])
			shf_out = sr1 >> ir[3:0];	// RSHFL
		else
			shf_out = lc3b_pkg::lc3b_word'($signed(sr1) >>> ir[3:0]);	// RSHFA
	end

	always_comb begin
		if (ctrl[lc3b_pkg::ctrl_addr_sel]) begin
			addr_base = pc;
			addr_off = ctrl[lc3b_pkg::ctrl_jsr_op] ? sext11 << 1 : sext9 << 1;
		end else begin
			addr_base = sr1;
			if (ctrl[lc3b_pkg::ctrl_jmp_op] | ctrl[lc3b_pkg::ctrl_jsr_op])
				addr_off = '0;	// JMP and JSRR jump to BaseR
			else if (ctrl[lc3b_pkg::ctrl_byte_op])
				addr_off = sext6;	// Byte offset
			else
				addr_off = sext6 << 1;	// Word offset
		end
	end

	assign address = addr_base + addr_off;
	assign result = (alu_op == lc3b_pkg::alu_shift) ? shf_out : alu_out;

endmodule

/* src/lc3b_mem_stage.sv */
`timescale 1ns/1ps
module lc3b_mem_stage (
	input lc3b_pkg::lc3b_ctrl ctrl,
	input logic valid,
	input lc3b_pkg::lc3b_word address,
	input lc3b_pkg::lc3b_word store_data,
	input lc3b_pkg::lc3b_cc ir_nzp,
	input lc3b_pkg::lc3b_cc cc,
	input lc3b_pkg::lc3b_word dmem_rdata,
	input logic dmem_resp,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic [1:0] dmem_byte_enable,
	output lc3b_pkg::lc3b_word load_data,
	output logic mem_stall,
	output logic redirect,
	output lc3b_pkg::lc3b_word target
);

	logic byte_op;
	logic access;
	logic br_taken;
	logic [7:0] rd_byte;

	assign byte_op = ctrl[lc3b_pkg::ctrl_byte_op];

	assign dmem_read = valid & ctrl[lc3b_pkg::ctrl_mem_read];
	assign dmem_write = valid & ctrl[lc3b_pkg::ctrl_mem_write];
	assign access = dmem_read | dmem_write;

	// Byte stores put the low byte on both lanes
	assign dmem_wdata = byte_op ? {store_data[7:0], store_data[7:0]} : store_data;

	always_comb begin
		if (!access)
			dmem_byte_enable = 2'b00;
		else if (!byte_op)
			dmem_byte_enable = 2'b11;	// Whole word
		else if (address[0])
			dmem_byte_enable = 2'b10;	// High lane on odd address
		else
			dmem_byte_enable = 2'b01;
	end

	assign rd_byte = address[0] ? dmem_rdata[15:8] : dmem_rdata[7:0];
	assign load_data = byte_op ? {8'h00, rd_byte} : dmem_rdata;	// LDB zero-extends

	// Whole pipe holds until the data port answers
	assign mem_stall = access & ~dmem_resp;

	assign br_taken = ctrl[lc3b_pkg::ctrl_br_op] & (|(ir_nzp & cc));
	assign redirect = valid & (br_taken | ctrl[lc3b_pkg::ctrl_jmp_op]
		| ctrl[lc3b_pkg::ctrl_jsr_op]);
	assign target = address;	// Computed in EX

endmodule

/* src/lc3b_pkg.sv */
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;	// Data and address word
	typedef logic [2:0] lc3b_reg;	// Register id
	typedef logic [2:0] lc3b_cc;	// Condition code as n, z, p
	typedef logic [15:0] lc3b_ctrl;	// Control word carried down the pipe

	typedef enum logic [3:0] {
		op_br = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_jsr = 4'b0100,	// JSR and JSRR, split by IR[11]
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_rti = 4'b1000,
		op_not = 4'b1001,
		op_ldi = 4'b1010,
		op_sti = 4'b1011,
		op_jmp = 4'b1100,
		op_shf = 4'b1101,
		op_lea = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	localparam int ctrl_ld_reg = 0;	// Writes a register in WB
	localparam int ctrl_ld_cc = 1;	// Writes the condition codes in WB
	localparam int ctrl_sr2_needed = 2;
	localparam int ctrl_sr1_needed = 3;
	localparam int ctrl_alu_op = 4;	// Low bit of a 2-bit field
	localparam int ctrl_use_imm5 = 6;
	localparam int ctrl_addr_sel = 7;	// PC-relative address when set
	localparam int ctrl_mem_read = 8;
	localparam int ctrl_mem_write = 9;
	localparam int ctrl_byte_op = 10;
	localparam int ctrl_br_op = 11;
	localparam int ctrl_jmp_op = 12;
	localparam int ctrl_jsr_op = 13;
	localparam int ctrl_wb_sel = 14;	// Low bit of a 2-bit field

	localparam logic [1:0] alu_add = 2'b00;
	localparam logic [1:0] alu_and = 2'b01;
	localparam logic [1:0] alu_not = 2'b10;
	localparam logic [1:0] alu_shift = 2'b11;	// Result comes from the shifter

	localparam logic [1:0] wb_alu = 2'b00;
	localparam logic [1:0] wb_addr = 2'b01;	// LEA
	localparam logic [1:0] wb_load = 2'b10;
	localparam logic [1:0] wb_pc = 2'b11;	// Return address for JSR

endpackage

/* src/lc3b_regfile.sv */
`timescale 1ns/1ps
module lc3b_regfile (
	input logic clk,
	input logic rst_n,
	input logic load,
	input lc3b_pkg::lc3b_reg dest,
	input lc3b_pkg::lc3b_word in,
	input lc3b_pkg::lc3b_reg src_a,
	input lc3b_pkg::lc3b_reg src_b,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b
);

	lc3b_pkg::lc3b_word regs [8];	// R0 to R7

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// Same-cycle write shows up on the read ports
	assign reg_a = (load && dest == src_a) ? in : regs[src_a];
	assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule
